// File: isa_pkg.sv
package isa_pkg;

	// Lowest bit of each instruction field.
	localparam int op_lsb = 26;
	localparam int rs_lsb = 21;
	localparam int rt_lsb = 16;
	localparam int rd_lsb = 11;
	localparam int shamt_lsb = 6;
	localparam int funct_lsb = 0;
	localparam int imm_lsb = 0;
	localparam int target_lsb = 0;

	localparam logic [5:0] op_special = 6'b000000;
	localparam logic [5:0] op_ori = 6'b001101;
	localparam logic [5:0] op_lui = 6'b001111;
	localparam logic [5:0] op_lw = 6'b100011;
	localparam logic [5:0] op_sw = 6'b101011;
	localparam logic [5:0] op_beq = 6'b000100;
	localparam logic [5:0] op_j = 6'b000010;
	localparam logic [5:0] op_jal = 6'b000011;

	localparam logic [5:0] funct_addu = 6'b100001;
	localparam logic [5:0] funct_subu = 6'b100011;
	localparam logic [5:0] funct_jr = 6'b001000;
	localparam logic [5:0] funct_movz = 6'b001010;

	localparam logic [4:0] shamt_zero = 5'd0;
	localparam logic [4:0] reg_zero = 5'd0;
	localparam logic [4:0] reg_ra = 5'd31;

	localparam logic [31:0] reset_pc = 32'h0000_0000;

	typedef enum logic [3:0] {
		kind_unknown, kind_nop, kind_addu, kind_subu, kind_ori, kind_lui, kind_lw,
		kind_sw, kind_beq, kind_j, kind_jal, kind_jr, kind_movz
	} instr_kind_t;

	// Datapath classes group the kinds that use the pipeline the same way.
	typedef enum logic [3:0] {
		cls_nop, cls_cal_r, cls_cal_i, cls_load, cls_store, cls_branch, cls_jump_i,
		cls_jump_r, cls_cmov
	} dp_class_t;

endpackage

// File: pipe_pkg.sv
package pipe_pkg;

	// The data memory holds 256 words.
	localparam int dm_words = 256;
	localparam int dm_addr_bits = 8;

	typedef enum logic [2:0] {fwd_orig, fwd_e_link, fwd_m_alu, fwd_m_link, fwd_w_rf} fwd_sel_t;
	typedef enum logic [1:0] {npc_seq, npc_beq, npc_jump, npc_reg} npc_mode_t;
	typedef enum logic [1:0] {ext_sign, ext_zero, ext_upper} ext_mode_t;
	typedef enum logic [1:0] {alu_add, alu_sub, alu_or, alu_pass_b} alu_op_t;
	typedef enum logic [1:0] {wb_alu, wb_mem, wb_link} wb_src_t;

	typedef struct packed {
		logic pc_en;
		npc_mode_t npc_mode;
	} f_ctrl_t;

	typedef struct packed {
		ext_mode_t ext_mode;
		logic [4:0] rs;
		logic [4:0] rt;
		fwd_sel_t fwd1;
		fwd_sel_t fwd2;
	} d_ctrl_t;

	typedef struct packed {
		logic alu_src;
		alu_op_t alu_op;
		fwd_sel_t fwd1;
		fwd_sel_t fwd2;
	} e_ctrl_t;

	typedef struct packed {
		logic dm_we;
		fwd_sel_t fwd_store;
	} m_ctrl_t;

	typedef struct packed {
		logic rf_we;
		wb_src_t wb_src;
		logic [4:0] waddr;
	} w_ctrl_t;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] instr;
	} d_stage_t;

	// The immediate is extended in E, so the raw field and its mode travel with it.
	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] rs_val;
		logic [31:0] rt_val;
		logic [15:0] imm;
		ext_mode_t ext_mode;
	} e_stage_t;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] alu;
		logic [31:0] rt_val;
	} m_stage_t;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] alu;
		logic [31:0] mem;
	} w_stage_t;

	typedef struct packed {
		logic valid;
		logic [4:0] addr;
		logic [31:0] data;
	} wb_event_t;

	typedef struct packed {
		logic valid;
		logic [31:0] addr;
		logic [31:0] data;
	} store_event_t;

endpackage

// File: instr_decode.sv
`timescale 1ns/10ps

module instr_decode (
	input logic [31:0] instr,
	output isa_pkg::instr_kind_t kind,
	output isa_pkg::dp_class_t dp_class
);
	import isa_pkg::*;

	logic [5:0] op;
	logic [5:0] funct;
	logic [4:0] rs;
	logic [4:0] rt;
	logic [4:0] rd;
	logic [4:0] shamt;

	assign op = instr[op_lsb +: 6];
	assign funct = instr[funct_lsb +: 6];
	assign rs = instr[rs_lsb +: 5];
	assign rt = instr[rt_lsb +: 5];
	assign rd = instr[rd_lsb +: 5];
	assign shamt = instr[shamt_lsb +: 5];

	// The all-zero word is nop, checked before the special opcode space.
	always_comb begin
		kind = kind_unknown;
		if (instr == '0) begin
			kind = kind_nop;
		end else if (op == op_special) begin
			if (shamt == shamt_zero && funct == funct_addu)
				kind = kind_addu;
			if (shamt == shamt_zero && funct == funct_subu)
				kind = kind_subu;
			if (shamt == shamt_zero && funct == funct_movz)
				kind = kind_movz;
			if (shamt == shamt_zero && funct == funct_jr && rt == reg_zero && rd == reg_zero)
				kind = kind_jr;
		end else begin
			case (op)
				op_ori: kind = kind_ori;
				op_lui: kind = (rs == reg_zero) ? kind_lui : kind_unknown;
				op_lw: kind = kind_lw;
				op_sw: kind = kind_sw;
				op_beq: kind = kind_beq;
				op_j: kind = kind_j;
				op_jal: kind = kind_jal;
				default: kind = kind_unknown;
			endcase
		end
	end

	always_comb begin
		case (kind)
			kind_addu, kind_subu: dp_class = cls_cal_r;
			kind_ori, kind_lui: dp_class = cls_cal_i;
			kind_lw: dp_class = cls_load;
			kind_sw: dp_class = cls_store;
			kind_beq: dp_class = cls_branch;
			kind_j, kind_jal: dp_class = cls_jump_i;
			kind_jr: dp_class = cls_jump_r;
			kind_movz: dp_class = cls_cmov;
			default: dp_class = cls_nop;
		endcase
	end

endmodule

// File: stage_reg.sv
`timescale 1ns/10ps

module stage_reg #(
	parameter type payload_t = logic [31:0]
) (
	input logic clk,
	input logic reset,
	input logic en,
	input logic clear,
	input payload_t d,
	output payload_t q
);

	// Clear wins over enable, so a bubble enters even when the stage advances.
	always_ff @(posedge clk) begin
		if (reset || clear)
			q <= '0;
		else if (en)
			q <= d;
	end

endmodule

// File: reg_file.sv
`timescale 1ns/10ps

module reg_file (
	input logic clk,
	input logic reset,
	input logic [4:0] raddr1,
	input logic [4:0] raddr2,
	output logic [31:0] rdata1,
	output logic [31:0] rdata2,
	input logic we,
	input logic [4:0] waddr,
	input logic [31:0] wdata
);
	import isa_pkg::*;

	// Register 0 has no storage.
	logic [31:0] regs [1:31];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (we && waddr != reg_zero) begin
			regs[waddr] <= wdata;
		end
	end

	// A read of the register being written sees the new value.
	always_comb begin
		if (raddr1 == reg_zero)
			rdata1 = '0;
		else if (we && raddr1 == waddr)
			rdata1 = wdata;
		else
			rdata1 = regs[raddr1];
		if (raddr2 == reg_zero)
			rdata2 = '0;
		else if (we && raddr2 == waddr)
			rdata2 = wdata;
		else
			rdata2 = regs[raddr2];
	end

endmodule

// File: exec_unit.sv
`timescale 1ns/10ps

module exec_unit (
	input pipe_pkg::ext_mode_t ext_mode,
	input logic [15:0] imm,
	input pipe_pkg::alu_op_t alu_op,
	input logic alu_src,
	input logic [31:0] a,
	input logic [31:0] b,
	output logic [31:0] result,
	output logic [31:0] ext_imm
);
	import pipe_pkg::*;

	logic [31:0] b_sel;

	always_comb begin
		case (ext_mode)
			ext_zero: ext_imm = {16'h0000, imm};
			ext_upper: ext_imm = {imm, 16'h0000};
			default: ext_imm = {{16{imm[15]}}, imm};
		endcase
	end

	// alu_src set means the immediate replaces the rt operand.
	assign b_sel = alu_src ? ext_imm : b;

	always_comb begin
		case (alu_op)
			alu_sub: result = a - b_sel;
			alu_or: result = a | b_sel;
			alu_pass_b: result = b_sel;
			default: result = a + b_sel;
		endcase
	end

endmodule

// File: hazard_ctrl.sv
`timescale 1ns/10ps

module hazard_ctrl (
	input logic clk,
	input logic reset,
	input logic [31:0] d_instr,
	input logic [31:0] d_rt_val,
	output pipe_pkg::f_ctrl_t f_ctrl,
	output pipe_pkg::d_ctrl_t d_ctrl,
	output pipe_pkg::e_ctrl_t e_ctrl,
	output pipe_pkg::m_ctrl_t m_ctrl,
	output pipe_pkg::w_ctrl_t w_ctrl
);
	import isa_pkg::*;
	import pipe_pkg::*;

	logic [31:0] e_instr;
	logic [31:0] m_instr;
	logic [31:0] w_instr;
	instr_kind_t d_kind;
	instr_kind_t e_kind;
	instr_kind_t m_kind;
	instr_kind_t w_kind;
	dp_class_t d_cls;
	dp_class_t e_cls;
	dp_class_t m_cls;
	dp_class_t w_cls;
	logic [4:0] d_rs;
	logic [4:0] d_rt;
	logic [4:0] d_dst;
	logic [4:0] e_rs;
	logic [4:0] e_rt;
	logic [4:0] e_dst;
	logic [4:0] m_rt;
	logic [4:0] m_dst;
	logic [4:0] w_dst;
	logic [2:0] t_use_rs;
	logic [2:0] t_use_rt;
	logic [2:0] t_new_e;
	logic [2:0] t_new_m;
	logic stall;

	instr_decode d_dec (.instr(d_instr), .kind(d_kind), .dp_class(d_cls));
	instr_decode e_dec (.instr(e_instr), .kind(e_kind), .dp_class(e_cls));
	instr_decode m_dec (.instr(m_instr), .kind(m_kind), .dp_class(m_cls));
	instr_decode w_dec (.instr(w_instr), .kind(w_kind), .dp_class(w_cls));

	function automatic logic hit(input logic [4:0] src, input logic [4:0] dst);
		return (src == dst) && (src != reg_zero);
	endfunction

	// Newest ready producer in M or W. A load in M is never picked here,
	// because the stall keeps its consumer out of E until the load is in W.
	function automatic fwd_sel_t fwd_from_m_w(input logic [4:0] src);
		if (hit(src, m_dst) && m_cls == cls_jump_i)
			return fwd_m_link;
		if (hit(src, m_dst) && m_cls inside {cls_cal_r, cls_cal_i, cls_cmov})
			return fwd_m_alu;
		if (hit(src, w_dst))
			return fwd_w_rf;
		return fwd_orig;
	endfunction

	always_comb begin
		d_rs = reg_zero;
		d_rt = reg_zero;
		if (d_cls inside {cls_cal_r, cls_cal_i, cls_load, cls_store, cls_branch, cls_jump_r,
				cls_cmov})
			d_rs = d_instr[rs_lsb +: 5];
		if (d_cls inside {cls_cal_r, cls_store, cls_branch, cls_cmov})
			d_rt = d_instr[rt_lsb +: 5];
	end

	// movz picks its destination here, from the forwarded rt value.
	always_comb begin
		case (d_cls)
			cls_cal_r: d_dst = d_instr[rd_lsb +: 5];
			cls_cal_i, cls_load: d_dst = d_instr[rt_lsb +: 5];
			cls_jump_i: d_dst = (d_kind == kind_jal) ? reg_ra : reg_zero;
			cls_cmov: d_dst = (d_rt_val == '0) ? d_instr[rd_lsb +: 5] : reg_zero;
			default: d_dst = reg_zero;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			e_instr <= '0;
			m_instr <= '0;
			w_instr <= '0;
			e_rs <= reg_zero;
			e_rt <= reg_zero;
			e_dst <= reg_zero;
			m_rt <= reg_zero;
			m_dst <= reg_zero;
			w_dst <= reg_zero;
		end else begin
			// A stall sends a bubble into E while D holds.
			e_instr <= stall ? '0 : d_instr;
			e_rs <= stall ? reg_zero : d_rs;
			e_rt <= stall ? reg_zero : d_rt;
			e_dst <= stall ? reg_zero : d_dst;
			m_instr <= e_instr;
			m_rt <= e_rt;
			m_dst <= e_dst;
			w_instr <= m_instr;
			w_dst <= m_dst;
		end
	end

	// Cycles until D needs each operand, and until E or M has its result.
	always_comb begin
		case (d_cls)
			cls_branch, cls_jump_r: t_use_rs = 3'd0;
			cls_cal_r, cls_cal_i, cls_load, cls_store, cls_cmov: t_use_rs = 3'd1;
			default: t_use_rs = 3'd7;
		endcase
		case (d_cls)
			cls_branch, cls_cmov: t_use_rt = 3'd0;
			cls_cal_r: t_use_rt = 3'd1;
			cls_store: t_use_rt = 3'd2;
			default: t_use_rt = 3'd7;
		endcase
		case (e_cls)
			cls_load: t_new_e = 3'd2;
			cls_cal_r, cls_cal_i, cls_cmov: t_new_e = 3'd1;
			default: t_new_e = 3'd0;
		endcase
		t_new_m = (m_cls == cls_load) ? 3'd1 : 3'd0;
	end

	assign stall = (hit(d_rs, e_dst) && t_use_rs < t_new_e) ||
		(hit(d_rs, m_dst) && t_use_rs < t_new_m) ||
		(hit(d_rt, e_dst) && t_use_rt < t_new_e) ||
		(hit(d_rt, m_dst) && t_use_rt < t_new_m);

	always_comb begin
		f_ctrl.pc_en = !stall;
		case (d_cls)
			cls_branch: f_ctrl.npc_mode = npc_beq;
			cls_jump_i: f_ctrl.npc_mode = npc_jump;
			cls_jump_r: f_ctrl.npc_mode = npc_reg;
			default: f_ctrl.npc_mode = npc_seq;
		endcase

		case (d_kind)
			kind_ori: d_ctrl.ext_mode = ext_zero;
			kind_lui: d_ctrl.ext_mode = ext_upper;
			default: d_ctrl.ext_mode = ext_sign;
		endcase
		d_ctrl.rs = d_rs;
		d_ctrl.rt = d_rt;
		d_ctrl.fwd1 = (hit(d_rs, e_dst) && e_cls == cls_jump_i) ? fwd_e_link : fwd_from_m_w(d_rs);
		d_ctrl.fwd2 = (hit(d_rt, e_dst) && e_cls == cls_jump_i) ? fwd_e_link : fwd_from_m_w(d_rt);
	end

	// movz runs as rs OR rt, which equals rs whenever it writes.
	always_comb begin
		e_ctrl.alu_src = e_cls inside {cls_cal_i, cls_load, cls_store};
		case (e_kind)
			kind_subu: e_ctrl.alu_op = alu_sub;
			kind_ori, kind_movz: e_ctrl.alu_op = alu_or;
			kind_lui: e_ctrl.alu_op = alu_pass_b;
			default: e_ctrl.alu_op = alu_add;
		endcase
		e_ctrl.fwd1 = fwd_from_m_w(e_rs);
		e_ctrl.fwd2 = fwd_from_m_w(e_rt);

		m_ctrl.dm_we = (m_kind == kind_sw);
		m_ctrl.fwd_store = hit(m_rt, w_dst) ? fwd_w_rf : fwd_orig;

		w_ctrl.rf_we = (w_cls inside {cls_cal_r, cls_cal_i, cls_load, cls_jump_i, cls_cmov}) &&
			(w_dst != reg_zero);
		case (w_kind)
			kind_lw: w_ctrl.wb_src = wb_mem;
			kind_jal: w_ctrl.wb_src = wb_link;
			default: w_ctrl.wb_src = wb_alu;
		endcase
		w_ctrl.waddr = w_dst;
	end

endmodule

// File: mips_core.sv
`timescale 1ns/10ps

module mips_core (
	input logic clk,
	input logic reset,
	output logic [31:0] imem_addr,
	input logic [31:0] imem_data,
	output pipe_pkg::wb_event_t wb,
	output pipe_pkg::store_event_t store
);
	import isa_pkg::*;
	import pipe_pkg::*;

	f_ctrl_t f_ctrl;
	d_ctrl_t d_ctrl;
	e_ctrl_t e_ctrl;
	m_ctrl_t m_ctrl;
	w_ctrl_t w_ctrl;
	d_stage_t d_next;
	d_stage_t d_q;
	e_stage_t e_next;
	e_stage_t e_q;
	m_stage_t m_next;
	m_stage_t m_q;
	w_stage_t w_next;
	w_stage_t w_q;
	logic [31:0] pc;
	logic [31:0] npc;
	logic [31:0] d_pc4;
	logic [31:0] rf_rdata1;
	logic [31:0] rf_rdata2;
	logic [31:0] d_rs_val;
	logic [31:0] d_rt_val;
	logic [31:0] e_a;
	logic [31:0] e_b;
	logic [31:0] e_result;
	logic [31:0] e_link;
	logic [31:0] m_link;
	logic [31:0] m_store_data;
	logic [31:0] w_value;
	logic [31:0] dmem [dm_words];

	function automatic logic [31:0] fwd_mux(input fwd_sel_t sel, input logic [31:0] orig);
		case (sel)
			fwd_e_link: return e_link;
			fwd_m_alu: return m_q.alu;
			fwd_m_link: return m_link;
			fwd_w_rf: return w_value;
			default: return orig;
		endcase
	endfunction

	hazard_ctrl hazard_ctrl_inst (
		.clk(clk),
		.reset(reset),
		.d_instr(d_q.instr),
		.d_rt_val(d_rt_val),
		.f_ctrl(f_ctrl),
		.d_ctrl(d_ctrl),
		.e_ctrl(e_ctrl),
		.m_ctrl(m_ctrl),
		.w_ctrl(w_ctrl)
	);

	// The redirect from D lands after the delay slot, which F fetches now.
	assign imem_addr = pc;
	assign d_pc4 = d_q.pc + 32'd4;

	always_comb begin
		case (f_ctrl.npc_mode)
			npc_beq: npc = (d_rs_val == d_rt_val) ?
				d_pc4 + {{14{d_q.instr[imm_lsb + 15]}}, d_q.instr[imm_lsb +: 16], 2'b00} :
				pc + 32'd4;
			npc_jump: npc = {d_pc4[31:28], d_q.instr[target_lsb +: 26], 2'b00};
			npc_reg: npc = d_rs_val;
			default: npc = pc + 32'd4;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			pc <= reset_pc;
		else if (f_ctrl.pc_en)
			pc <= npc;
	end

	assign d_next = '{pc: pc, instr: imem_data};

	stage_reg #(.payload_t(d_stage_t)) d_reg (
		.clk(clk), .reset(reset), .en(f_ctrl.pc_en), .clear(1'b0), .d(d_next), .q(d_q)
	);

	reg_file reg_file_inst (
		.clk(clk),
		.reset(reset),
		.raddr1(d_ctrl.rs),
		.raddr2(d_ctrl.rt),
		.rdata1(rf_rdata1),
		.rdata2(rf_rdata2),
		.we(w_ctrl.rf_we),
		.waddr(w_ctrl.waddr),
		.wdata(w_value)
	);

	always_comb begin
		d_rs_val = fwd_mux(d_ctrl.fwd1, rf_rdata1);
		d_rt_val = fwd_mux(d_ctrl.fwd2, rf_rdata2);
	end

	assign e_next = '{pc: d_q.pc, rs_val: d_rs_val, rt_val: d_rt_val,
		imm: d_q.instr[imm_lsb +: 16], ext_mode: d_ctrl.ext_mode};

	stage_reg #(.payload_t(e_stage_t)) e_reg (
		.clk(clk), .reset(reset), .en(1'b1), .clear(!f_ctrl.pc_en), .d(e_next), .q(e_q)
	);

	assign e_link = e_q.pc + 32'd8;

	always_comb begin
		e_a = fwd_mux(e_ctrl.fwd1, e_q.rs_val);
		e_b = fwd_mux(e_ctrl.fwd2, e_q.rt_val);
	end

	exec_unit exec_unit_inst (
		.ext_mode(e_q.ext_mode),
		.imm(e_q.imm),
		.alu_op(e_ctrl.alu_op),
		.alu_src(e_ctrl.alu_src),
		.a(e_a),
		.b(e_b),
		.result(e_result),
		.ext_imm()
	);

	assign m_next = '{pc: e_q.pc, alu: e_result, rt_val: e_b};

	stage_reg #(.payload_t(m_stage_t)) m_reg (
		.clk(clk), .reset(reset), .en(1'b1), .clear(1'b0), .d(m_next), .q(m_q)
	);

	assign m_link = m_q.pc + 32'd8;

	always_comb begin
		m_store_data = fwd_mux(m_ctrl.fwd_store, m_q.rt_val);
	end

	// Word addressed; the two low address bits are ignored.
	always_ff @(posedge clk) begin
		if (m_ctrl.dm_we)
			dmem[m_q.alu[dm_addr_bits + 1:2]] <= m_store_data;
	end

	assign store = '{valid: m_ctrl.dm_we, addr: m_q.alu, data: m_store_data};
	assign w_next = '{pc: m_q.pc, alu: m_q.alu, mem: dmem[m_q.alu[dm_addr_bits + 1:2]]};

	stage_reg #(.payload_t(w_stage_t)) w_reg (
		.clk(clk), .reset(reset), .en(1'b1), .clear(1'b0), .d(w_next), .q(w_q)
	);

	always_comb begin
		case (w_ctrl.wb_src)
			wb_mem: w_value = w_q.mem;
			wb_link: w_value = w_q.pc + 32'd8;
			default: w_value = w_q.alu;
		endcase
	end

	assign wb = '{valid: w_ctrl.rf_we, addr: w_ctrl.waddr, data: w_value};

endmodule

// File: tb_mips_core.sv
`timescale 1ns/10ps

module tb_mips_core;
	import pipe_pkg::*;

	localparam int clk_period = 40;
	localparam int reset_cycles = 8;
	localparam int cycles_per_instr = 20;
	localparam int drain_cycles = 10;
	localparam int stim_depth = 128;
	// Word offsets of the program and the event records inside the stim file.
	localparam int prog_base = 16;
	localparam int event_base = 64;
	localparam logic [31:0] kind_wb = 32'd1;
	localparam logic [31:0] kind_store = 32'd2;

	logic clk = 1'b0;
	logic reset;
	logic [31:0] imem_addr;
	logic [31:0] imem_data;
	logic [29:0] imem_word;
	wb_event_t wb;
	store_event_t store;
	logic [31:0] stim [0:stim_depth - 1];
	logic [31:0] prog_len;
	int num_events;
	int next_event = 0;
	logic stim_loaded = 1'b0;

	mips_core mips_core_inst (
		.clk(clk),
		.reset(reset),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.wb(wb),
		.store(store)
	);

	always #(clk_period / 2) clk = ~clk;

	// Addresses past the end of the program read as nop.
	assign imem_word = imem_addr[31:2];
	assign imem_data = (imem_word < prog_len) ? stim[prog_base + imem_word] : 32'h0000_0000;

	task automatic stop_with_failure();
		$display("Regression failed");
		$fatal(1, "Simulation stopped on the first error.");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("** Error at time %0t: %s is %h, expected %h", $time, name, actual,
				expected);
			stop_with_failure();
		end
	endtask

	// Each record is three words: kind, address and data.
	task automatic check_event(input logic [31:0] kind, input logic [31:0] addr,
			input logic [31:0] data, input string name);
		int base;
		base = event_base + 3 * next_event;
		if (next_event >= num_events) begin
			$display("A %s event arrived at time %0t after all %0d expected events were seen",
				name, $time, num_events);
			stop_with_failure();
		end else begin
			check_value({name, " event kind"}, kind, stim[base]);
			check_value({name, ".addr"}, addr, stim[base + 1]);
			check_value({name, ".data"}, data, stim[base + 2]);
			next_event++;
		end
	endtask

	// W is older than M, so a writeback is checked before a store on the same edge.
	always @(posedge clk) begin
		if (!reset && wb.valid)
			check_event(kind_wb, {27'd0, wb.addr}, wb.data, "wb");
		if (!reset && store.valid)
			check_event(kind_store, store.addr, store.data, "store");
	end

	initial begin
		reset = 1'b1;
		prog_len = 32'd0;
		$readmemh("mips_stim.txt", stim);
		prog_len = stim[0];
		num_events = stim[1];
		if (prog_len == 0 || prog_len > event_base - prog_base ||
				event_base + 3 * num_events > stim_depth) begin
			$display("The stim file header gives an empty program or too many records");
			stop_with_failure();
		end else begin
			stim_loaded = 1'b1;
			repeat (reset_cycles) @(posedge clk);
			reset <= 1'b0;
			wait (next_event == num_events);
			// Extra cycles let any wrong-path event show up before the verdict.
			repeat (drain_cycles) @(posedge clk);
			$display("Regression passed");
			$finish;
		end
	end

	initial begin : watchdog
		int limit_cycles;
		wait (stim_loaded);
		limit_cycles = reset_cycles + cycles_per_instr * int'(prog_len);
		repeat (limit_cycles) @(posedge clk);
		$display("Timeout after %0d cycles with %0d of %0d expected events seen",
			limit_cycles, next_event, num_events);
		stop_with_failure();
	end

endmodule

// File: mips_stim.txt
// Words 0 and 1 hold the program length and the expected event count.
// Program from @010, one word per instruction. Events from @040 as kind, addr, data,
// with kind 1 for a register writeback and kind 2 for a store.
@000
00000017 0000000e
@010
34011234 3c02abcd 00221821 00612023 // ori, lui, addu, subu
34050040 aca30000 8ca60000 00c13821 // ori, sw, lw, addu on the loaded value
10210002 34080008 34090bad 10220003 // beq taken, delay slot, wrong path, beq not taken
340a000a 0c000014 340b000b 0020600a // delay slot, jal, delay slot, movz with rt zero
0022680a 00210021 08000012 00000000 // movz with rt nonzero, addu to $0, j to self, nop
03e00008 340e000e 34090bad          // jr, delay slot, wrong path
@040
00000001 00000001 00001234
00000001 00000002 abcd0000
00000001 00000003 abcd1234
00000001 00000004 abcd0000
00000001 00000005 00000040
00000002 00000040 abcd1234
00000001 00000006 abcd1234
00000001 00000007 abcd2468
00000001 00000008 00000008
00000001 0000000a 0000000a
00000001 0000001f 0000003c
00000001 0000000b 0000000b
00000001 0000000e 0000000e
00000001 0000000c 00001234

// File: build.f
isa_pkg.sv
pipe_pkg.sv
instr_decode.sv
stage_reg.sv
reg_file.sv
exec_unit.sv
hazard_ctrl.sv
mips_core.sv
tb_mips_core.sv

// File: Bender.yml
package:
  name: mips_core

sources:
  - isa_pkg.sv
  - pipe_pkg.sv
  - instr_decode.sv
  - stage_reg.sv
  - reg_file.sv
  - exec_unit.sv
  - hazard_ctrl.sv
  - mips_core.sv
  - target: simulation
    files:
      - tb_mips_core.sv
